/* mips_pkg.sv */
`default_nettype none

package mips_pkg;

	////////////////////////////////////////////////////////////
	// widths
	////////////////////////////////////////////////////////////
	localparam int data_width     = 32;
	localparam int reg_addr_width = 5;
	localparam int reg_count      = 32;

	////////////////////////////////////////////////////////////
	// opcodes and function codes
	////////////////////////////////////////////////////////////
	localparam logic [5:0] op_rtype = 6'h00;
	localparam logic [5:0] op_j     = 6'h02;
	localparam logic [5:0] op_jal   = 6'h03;
	localparam logic [5:0] op_beq   = 6'h04;
	localparam logic [5:0] op_bne   = 6'h05;
	localparam logic [5:0] op_addi  = 6'h08;
	localparam logic [5:0] op_andi  = 6'h0c;
	localparam logic [5:0] op_ori   = 6'h0d;
	localparam logic [5:0] op_lui   = 6'h0f;
	localparam logic [5:0] op_lw    = 6'h23;
	localparam logic [5:0] op_sw    = 6'h2b;

	localparam logic [5:0] fn_sll = 6'h00;
	localparam logic [5:0] fn_jr  = 6'h08;
	localparam logic [5:0] fn_add = 6'h20;
	localparam logic [5:0] fn_sub = 6'h22;
	localparam logic [5:0] fn_and = 6'h24;
	localparam logic [5:0] fn_or  = 6'h25;
	localparam logic [5:0] fn_slt = 6'h2a;

	typedef enum logic [3:0] {
		alu_add   = 4'd0,
		alu_sub   = 4'd1,
		alu_and   = 4'd2,
		alu_or    = 4'd3,
		alu_slt   = 4'd4,
		alu_sll   = 4'd5,
		alu_lui   = 4'd6,
		alu_funct = 4'd7 // execute stage decodes the function field
	} alu_op_e;

	////////////////////////////////////////////////////////////
	// control groups and stage payloads
	////////////////////////////////////////////////////////////
	typedef struct packed {
		logic    reg_dst;   // rd instead of rt as destination
		logic    alu_src;   // immediate as second operand
		alu_op_e alu_op;
		logic    branch;
		logic    branch_ne;
		logic    jump;
		logic    jump_reg;
		logic    link;      // write pc+4 to ra
	} ex_ctrl_t;

	typedef struct packed {
		logic mem_read;
		logic mem_write;
	} mem_ctrl_t;

	typedef struct packed {
		logic reg_write;
		logic mem_to_reg;
	} wb_ctrl_t;

	typedef struct packed {
		ex_ctrl_t  ex;
		mem_ctrl_t mem;
		wb_ctrl_t  wb;
	} ctrl_t;

	typedef struct packed {
		logic [data_width-1:0] pc_plus4;
		logic [data_width-1:0] instr;
	} if_id_t;

	typedef struct packed {
		ctrl_t                     ctrl;
		logic [data_width-1:0]     pc_branch;
		logic [data_width-1:0]     reg1;
		logic [data_width-1:0]     reg2;
		logic [data_width-1:0]     imm_ext;
		logic [reg_addr_width-1:0] rs;
		logic [reg_addr_width-1:0] rt;
		logic [reg_addr_width-1:0] rd;
		logic [reg_addr_width-1:0] shamt;
	} id_ex_t;

	typedef struct packed {
		logic                      reg_write;
		logic [reg_addr_width-1:0] write_reg;
		logic [data_width-1:0]     write_data;
	} wb_port_t;

endpackage

`default_nettype wire

/* control_unit.sv */
`default_nettype none

module control_unit (
	input  wire  [5:0]            opcode,
	input  wire  [5:0]            funct,
	output mips_pkg::ctrl_t       ctrl
);

	logic funct_known;

	// r-type codes that the execute stage understands
	assign funct_known = funct inside {mips_pkg::fn_add, mips_pkg::fn_sub, mips_pkg::fn_and,
		mips_pkg::fn_or, mips_pkg::fn_slt, mips_pkg::fn_sll};

	always_comb
	begin
		ctrl = '0; // unknown opcodes decode to a nop
		case (opcode)
			mips_pkg::op_rtype:
			begin
				if (funct == mips_pkg::fn_jr)
				begin
					ctrl.ex.jump_reg = 1'b1; // no register write for jr
				end
				else if (funct_known)
				begin
					ctrl.ex.reg_dst   = 1'b1;
					ctrl.ex.alu_op    = mips_pkg::alu_funct;
					ctrl.wb.reg_write = 1'b1;
				end
			end
			mips_pkg::op_lw:
			begin
				ctrl.ex.alu_src    = 1'b1;
				ctrl.ex.alu_op     = mips_pkg::alu_add; // base + offset
				ctrl.mem.mem_read  = 1'b1;
				ctrl.wb.reg_write  = 1'b1;
				ctrl.wb.mem_to_reg = 1'b1;
			end
			mips_pkg::op_sw:
			begin
				ctrl.ex.alu_src    = 1'b1;
				ctrl.ex.alu_op     = mips_pkg::alu_add;
				ctrl.mem.mem_write = 1'b1;
			end
			mips_pkg::op_beq:
			begin
				ctrl.ex.branch = 1'b1;
				ctrl.ex.alu_op = mips_pkg::alu_sub; // compare by subtraction
			end
			mips_pkg::op_bne:
			begin
				ctrl.ex.branch_ne = 1'b1;
				ctrl.ex.alu_op    = mips_pkg::alu_sub;
			end
			mips_pkg::op_addi:
			begin
				ctrl.ex.alu_src   = 1'b1;
				ctrl.ex.alu_op    = mips_pkg::alu_add;
				ctrl.wb.reg_write = 1'b1;
			end
			mips_pkg::op_andi:
			begin
				ctrl.ex.alu_src   = 1'b1;
				ctrl.ex.alu_op    = mips_pkg::alu_and;
				ctrl.wb.reg_write = 1'b1;
			end
			mips_pkg::op_ori:
			begin
				ctrl.ex.alu_src   = 1'b1;
				ctrl.ex.alu_op    = mips_pkg::alu_or;
				ctrl.wb.reg_write = 1'b1;
			end
			mips_pkg::op_lui:
			begin
				ctrl.ex.alu_src   = 1'b1;
				ctrl.ex.alu_op    = mips_pkg::alu_lui;
				ctrl.wb.reg_write = 1'b1;
			end
			mips_pkg::op_j:
			begin
				ctrl.ex.jump = 1'b1;
			end
			mips_pkg::op_jal:
			begin
				ctrl.ex.jump      = 1'b1;
				ctrl.ex.link      = 1'b1; // return address goes to ra
				ctrl.wb.reg_write = 1'b1;
			end
			default:
			begin
				ctrl = '0;
			end
		endcase
	end

endmodule

`default_nettype wire

/* register_file.sv */
`default_nettype none

module register_file #(
	parameter bit debug_enable = 1'b1
)(
	input  wire                                  clk,
	input  wire                                  reset,
	input  wire mips_pkg::wb_port_t              wb,
	input  wire [mips_pkg::reg_addr_width-1:0]   rs_addr,
	input  wire [mips_pkg::reg_addr_width-1:0]   rt_addr,
	output logic [mips_pkg::data_width-1:0]      rs_data,
	output logic [mips_pkg::data_width-1:0]      rt_data,
	input  wire [mips_pkg::reg_addr_width-1:0]   debug_addr,
	output logic [mips_pkg::data_width-1:0]      debug_data
);

	logic [mips_pkg::data_width-1:0] regs [mips_pkg::reg_count];
	logic                            wr_en;

	assign wr_en = wb.reg_write && (wb.write_reg != '0); // r0 is never written

	// combinational read with bypass of the write in flight
	function automatic logic [mips_pkg::data_width-1:0] read_reg(
		input logic [mips_pkg::reg_addr_width-1:0] addr
	);
		logic [mips_pkg::data_width-1:0] value;
		value = regs[addr];
		if (wr_en && (wb.write_reg == addr))
			value = wb.write_data;
		return value;
	endfunction

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			for (int i = 0; i < mips_pkg::reg_count; i++)
				regs[i] <= '0;
		end
		else if (wr_en)
		begin
			regs[wb.write_reg] <= wb.write_data;
		end
	end

	always_comb
	begin
		rs_data = read_reg(rs_addr);
		rt_data = read_reg(rt_addr);
	end

	// debug port reads zero when disabled
	always_comb
	begin
		debug_data = debug_enable ? read_reg(debug_addr) : '0;
	end

	////////////////////////////////////////////////////////////
	// checks
	////////////////////////////////////////////////////////////
	a_reg_zero: assert property (@(posedge clk) disable iff (reset) regs[0] == '0)
		else $error("register zero holds a non-zero value");

endmodule

`default_nettype wire

/* hazard_unit.sv */
`default_nettype none

module hazard_unit (
	input  wire                                ex_mem_read,
	input  wire [mips_pkg::reg_addr_width-1:0] ex_rt,
	input  wire [mips_pkg::reg_addr_width-1:0] id_rs,
	input  wire [mips_pkg::reg_addr_width-1:0] id_rt,
	input  wire                                id_reads_rt,
	output logic                               stall
);

	logic load_live; // load in id/ex with a real destination
	logic rs_match;
	logic rt_match;

	assign load_live = ex_mem_read && (ex_rt != '0);
	assign rs_match  = (ex_rt == id_rs);
	assign rt_match  = id_reads_rt && (ex_rt == id_rt); // only r-type, store, branch

	// load-use pair needs one bubble
	assign stall = load_live && (rs_match || rt_match);

endmodule

`default_nettype wire

/* if_id_register.sv */
`default_nettype none

module if_id_register (
	input  wire                   clk,
	input  wire                   reset,
	input  wire mips_pkg::if_id_t fetch,
	input  wire                   stall,
	input  wire                   flush,
	output mips_pkg::if_id_t      if_id
);

	////////////////////////////////////////////////////////////
	// fetch/decode latch
	////////////////////////////////////////////////////////////
	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			if_id <= '0;
		end
		else if (flush)
		begin
			if_id <= '0; // flush wins over stall
		end
		else if (!stall)
		begin
			if_id <= fetch;
		end
	end

	// a stalled instruction stays in decode untouched
	a_hold_on_stall: assert property (@(posedge clk) disable iff (reset)
		(stall && !flush) |=> (if_id == $past(if_id)))
		else $error("if/id payload changed during stall");

endmodule

`default_nettype wire

/* id_ex_stage.sv */
`default_nettype none

module id_ex_stage #(
	parameter bit debug_enable = 1'b1
)(
	input  wire                                  clk,
	input  wire                                  reset,
	input  wire mips_pkg::if_id_t                if_id,
	input  wire mips_pkg::wb_port_t              wb,
	input  wire                                  flush,
	input  wire                                  halt_in,
	input  wire [mips_pkg::reg_addr_width-1:0]   debug_addr,
	output mips_pkg::id_ex_t                     id_ex,
	output logic                                 halt_out,
	output logic                                 stall,
	output logic                                 jump_taken,
	output logic                                 jump_reg_taken,
	output logic [mips_pkg::data_width-1:0]      jump_target,
	output logic [mips_pkg::data_width-1:0]      jump_reg_target,
	output logic [mips_pkg::data_width-1:0]      debug_data
);

	logic [5:0]                          opcode;
	logic [5:0]                          funct;
	logic [mips_pkg::reg_addr_width-1:0] rs;
	logic [mips_pkg::reg_addr_width-1:0] rt;
	logic [mips_pkg::reg_addr_width-1:0] rd;
	logic [mips_pkg::reg_addr_width-1:0] shamt;
	logic [15:0]                         imm;
	logic [25:0]                         jump_index;
	mips_pkg::ctrl_t                     dec_ctrl;
	logic [mips_pkg::data_width-1:0]     rs_data;
	logic [mips_pkg::data_width-1:0]     rt_data;
	logic                                id_reads_rt;
	logic                                hazard;
	mips_pkg::id_ex_t                    id_ex_d;

	////////////////////////////////////////////////////////////
	// instruction fields
	////////////////////////////////////////////////////////////
	assign opcode     = if_id.instr[31:26];
	assign rs         = if_id.instr[25:21];
	assign rt         = if_id.instr[20:16];
	assign rd         = if_id.instr[15:11];
	assign shamt      = if_id.instr[10:6];
	assign funct      = if_id.instr[5:0];
	assign imm        = if_id.instr[15:0];
	assign jump_index = if_id.instr[25:0];

	control_unit u_control (
		.opcode (opcode),
		.funct  (funct),
		.ctrl   (dec_ctrl)
	);

	register_file #(
		.debug_enable (debug_enable)
	) u_register_file (
		.clk        (clk),
		.reset      (reset),
		.wb         (wb),
		.rs_addr    (rs),
		.rt_addr    (rt),
		.rs_data    (rs_data),
		.rt_data    (rt_data),
		.debug_addr (debug_addr),
		.debug_data (debug_data)
	);

	// r-type, store and branch are the only rt readers
	assign id_reads_rt = dec_ctrl.ex.reg_dst | dec_ctrl.mem.mem_write |
		dec_ctrl.ex.branch | dec_ctrl.ex.branch_ne;

	hazard_unit u_hazard (
		.ex_mem_read (id_ex.ctrl.mem.mem_read),
		.ex_rt       (id_ex.rt),
		.id_rs       (rs),
		.id_rt       (rt),
		.id_reads_rt (id_reads_rt),
		.stall       (hazard)
	);

	////////////////////////////////////////////////////////////
	// outputs to fetch, all quiet during flush
	////////////////////////////////////////////////////////////
	assign stall          = !flush && hazard;
	assign jump_taken     = !flush && dec_ctrl.ex.jump;
	assign jump_reg_taken = !flush && dec_ctrl.ex.jump_reg;
	assign jump_target    = flush ? '0 : {if_id.pc_plus4[31:28], jump_index, 2'b00};
	assign jump_reg_target = flush ? '0 : rs_data;

	// next id/ex contents, ctrl zeroed for a bubble
	always_comb
	begin
		id_ex_d           = '0;
		id_ex_d.ctrl      = hazard ? '0 : dec_ctrl;
		id_ex_d.pc_branch = if_id.pc_plus4;
		id_ex_d.reg1      = rs_data;
		id_ex_d.reg2      = rt_data;
		id_ex_d.imm_ext   = {{16{imm[15]}}, imm}; // sign extension
		id_ex_d.rs        = rs;
		id_ex_d.rt        = rt;
		id_ex_d.rd        = rd;
		id_ex_d.shamt     = shamt;
	end

	always_ff @(posedge clk)
	begin
		if (reset || flush)
			id_ex <= '0;
		else
			id_ex <= id_ex_d;
	end

	always_ff @(posedge clk)
	begin
		if (reset)
			halt_out <= 1'b0;
		else
			halt_out <= halt_in; // flush does not touch halt
	end

	a_bubble_ctrl: assert property (@(posedge clk) disable iff (reset)
		(stall || flush) |=> (id_ex.ctrl == '0))
		else $error("id/ex ctrl not cleared after stall or flush");

endmodule

`default_nettype wire

/* decode_top.sv */
`default_nettype none

module decode_top #(
	parameter bit debug_enable = 1'b1
)(
	input  wire                                  clk,
	input  wire                                  reset,
	input  wire mips_pkg::if_id_t                fetch,
	input  wire mips_pkg::wb_port_t              wb,
	input  wire                                  flush,
	input  wire                                  halt_in,
	input  wire [mips_pkg::reg_addr_width-1:0]   debug_addr,
	output mips_pkg::id_ex_t                     id_ex,
	output logic                                 halt_out,
	output logic                                 stall,
	output logic                                 jump_taken,
	output logic                                 jump_reg_taken,
	output logic [mips_pkg::data_width-1:0]      jump_target,
	output logic [mips_pkg::data_width-1:0]      jump_reg_target,
	output logic [mips_pkg::data_width-1:0]      debug_data
);

	mips_pkg::if_id_t if_id; // decode-side view of the latch

	if_id_register u_if_id (
		.clk   (clk),
		.reset (reset),
		.fetch (fetch),
		.stall (stall),
		.flush (flush),
		.if_id (if_id)
	);

	id_ex_stage #(
		.debug_enable (debug_enable)
	) u_id_ex (
		.clk             (clk),
		.reset           (reset),
		.if_id           (if_id),
		.wb              (wb),
		.flush           (flush),
		.halt_in         (halt_in),
		.debug_addr      (debug_addr),
		.id_ex           (id_ex),
		.halt_out        (halt_out),
		.stall           (stall),
		.jump_taken      (jump_taken),
		.jump_reg_taken  (jump_reg_taken),
		.jump_target     (jump_target),
		.jump_reg_target (jump_reg_target),
		.debug_data      (debug_data)
	);

endmodule

`default_nettype wire

/* tb_decode_top.sv */
`default_nettype none

module tb_decode_top;
	timeunit 1ns;
	timeprecision 1ps;

	localparam int num_instr  = 300;
	localparam int clk_period = 8;
	localparam logic [5:0] opcodes [11] = '{mips_pkg::op_rtype, mips_pkg::op_lw, mips_pkg::op_sw,
		mips_pkg::op_beq, mips_pkg::op_bne, mips_pkg::op_addi, mips_pkg::op_andi,
		mips_pkg::op_ori, mips_pkg::op_lui, mips_pkg::op_j, mips_pkg::op_jal};
	localparam logic [5:0] functs [7] = '{mips_pkg::fn_jr, mips_pkg::fn_add, mips_pkg::fn_sub,
		mips_pkg::fn_and, mips_pkg::fn_or, mips_pkg::fn_slt, mips_pkg::fn_sll};

	logic               clk;
	logic               reset;
	mips_pkg::if_id_t   fetch;
	mips_pkg::wb_port_t wb;
	logic               flush;
	logic               halt_in;
	logic [4:0]         debug_addr;
	mips_pkg::id_ex_t   id_ex;
	logic               halt_out;
	logic               stall;
	logic               jump_taken;
	logic               jump_reg_taken;
	logic [31:0]        jump_target;
	logic [31:0]        jump_reg_target;
	logic [31:0]        debug_data;

	mips_pkg::if_id_t   m_if_id; // reference pipeline state
	mips_pkg::id_ex_t   m_id_ex;
	logic [31:0]        m_regs [32];
	logic               m_halt;
	mips_pkg::ctrl_t    m_ctrl;
	logic               m_reads_rt;
	logic               hazard;
	logic [3:0]         exp_flags; // stall, jump, jump_reg, halt
	logic [31:0]        exp_jump_target;
	logic [31:0]        exp_jr_target;
	logic [31:0]        exp_debug;
	mips_pkg::id_ex_t   exp_next;
	logic [31:0]        pc;
	int                 value_errors = 0;
	int                 other_errors = 0;

	decode_top DUT (.*);

	initial
	begin
		clk = 1'b0;
		forever #(clk_period / 2) clk = ~clk;
	end

	// main decoder written as one equation per control bit
	function automatic mips_pkg::ctrl_t ref_ctrl(input logic [31:0] instr);
		logic [5:0]      op;
		logic            alu_r;
		logic            alu_i;
		mips_pkg::ctrl_t c;
		op    = instr[31:26];
		alu_r = (op == mips_pkg::op_rtype) && (instr[5:0] inside {mips_pkg::fn_add,
			mips_pkg::fn_sub, mips_pkg::fn_and, mips_pkg::fn_or, mips_pkg::fn_slt, mips_pkg::fn_sll});
		alu_i = op inside {mips_pkg::op_addi, mips_pkg::op_andi, mips_pkg::op_ori, mips_pkg::op_lui};
		c = '0;
		c.ex.reg_dst  = alu_r;
		c.ex.alu_src  = alu_i || (op == mips_pkg::op_lw) || (op == mips_pkg::op_sw);
		c.ex.alu_op   = alu_r ? mips_pkg::alu_funct :
			(op inside {mips_pkg::op_beq, mips_pkg::op_bne}) ? mips_pkg::alu_sub :
			(op == mips_pkg::op_andi) ? mips_pkg::alu_and :
			(op == mips_pkg::op_ori) ? mips_pkg::alu_or :
			(op == mips_pkg::op_lui) ? mips_pkg::alu_lui : mips_pkg::alu_add;
		c.ex.branch    = (op == mips_pkg::op_beq);
		c.ex.branch_ne = (op == mips_pkg::op_bne);
		c.ex.jump      = (op == mips_pkg::op_j) || (op == mips_pkg::op_jal);
		c.ex.jump_reg  = (op == mips_pkg::op_rtype) && (instr[5:0] == mips_pkg::fn_jr);
		c.ex.link      = (op == mips_pkg::op_jal);
		c.mem.mem_read  = (op == mips_pkg::op_lw);
		c.mem.mem_write = (op == mips_pkg::op_sw);
		c.wb.reg_write  = alu_r || alu_i || (op == mips_pkg::op_lw) || (op == mips_pkg::op_jal);
		c.wb.mem_to_reg = (op == mips_pkg::op_lw);
		return c;
	endfunction

	// register value as decode sees it, pending writeback included
	function automatic logic [31:0] model_read(input logic [4:0] addr);
		if (wb.reg_write && (addr != 5'd0) && (wb.write_reg == addr))
			return wb.write_data;
		return m_regs[addr];
	endfunction

	function automatic logic [31:0] random_instr(input logic [31:0] prev);
		logic [5:0]  op;
		logic [4:0]  rs;
		logic [25:0] low;
		op  = opcodes[$urandom_range(0, 10)];
		low = 26'($urandom);
		rs  = low[25:21];
		if ((prev[31:26] == mips_pkg::op_lw) && ($urandom_range(0, 1) == 1))
			rs = prev[20:16]; // make load-use pairs common
		if (op == mips_pkg::op_rtype)
			return {op, rs, low[20:6], functs[$urandom_range(0, 6)]};
		return {op, rs, low[20:0]};
	endfunction

	////////////////////////////////////////////////////////////
	// reference model
	////////////////////////////////////////////////////////////
	always_comb
	begin
		m_ctrl     = ref_ctrl(m_if_id.instr);
		m_reads_rt = (m_if_id.instr[31:26] inside {mips_pkg::op_sw, mips_pkg::op_beq,
			mips_pkg::op_bne}) || (m_ctrl.ex.reg_dst && !m_ctrl.ex.jump_reg);
		hazard = m_id_ex.ctrl.mem.mem_read && (m_id_ex.rt != 5'd0) &&
			((m_id_ex.rt == m_if_id.instr[25:21]) ||
			(m_reads_rt && (m_id_ex.rt == m_if_id.instr[20:16])));
		exp_flags = {!flush && hazard, !flush && m_ctrl.ex.jump, !flush && m_ctrl.ex.jump_reg,
			m_halt};
		exp_jump_target = flush ? '0 : {m_if_id.pc_plus4[31:28], m_if_id.instr[25:0], 2'b00};
		exp_jr_target   = flush ? '0 : model_read(m_if_id.instr[25:21]);
		exp_debug       = model_read(debug_addr);
		exp_next           = '0;
		exp_next.ctrl      = hazard ? '0 : m_ctrl; // bubble on load-use
		exp_next.pc_branch = m_if_id.pc_plus4;
		exp_next.reg1      = model_read(m_if_id.instr[25:21]);
		exp_next.reg2      = model_read(m_if_id.instr[20:16]);
		exp_next.imm_ext   = 32'(signed'(m_if_id.instr[15:0]));
		exp_next.rs        = m_if_id.instr[25:21];
		exp_next.rt        = m_if_id.instr[20:16];
		exp_next.rd        = m_if_id.instr[15:11];
		exp_next.shamt     = m_if_id.instr[10:6];
	end

	always @(posedge clk)
	begin
		if (reset)
		begin
			m_if_id <= '0;
			m_id_ex <= '0;
			m_halt  <= 1'b0;
			for (int r = 0; r < 32; r++)
				m_regs[r] <= '0;
		end
		else
		begin
			m_halt <= halt_in; // halt ignores flush
			if (wb.reg_write && (wb.write_reg != 5'd0))
				m_regs[wb.write_reg] <= wb.write_data;
			m_if_id <= flush ? '0 : (hazard ? m_if_id : fetch);
			m_id_ex <= flush ? '0 : exp_next;
		end
	end

	////////////////////////////////////////////////////////////
	// checks
	////////////////////////////////////////////////////////////
	task automatic report_mismatch(input string name, input logic [191:0] got,
		input logic [191:0] expected);
		value_errors++;
		$display("Error at %0t: %s is %0h, expected %0h", $time, name, got, expected);
	endtask

	a_id_ex: assert property (@(posedge clk) disable iff (reset) id_ex == m_id_ex)
		else report_mismatch("id_ex", $sampled(id_ex), $sampled(m_id_ex));
	a_flags: assert property (@(posedge clk) disable iff (reset)
		{stall, jump_taken, jump_reg_taken, halt_out} == exp_flags)
		else report_mismatch("{stall,jump_taken,jump_reg_taken,halt_out}",
			$sampled({stall, jump_taken, jump_reg_taken, halt_out}), $sampled(exp_flags));
	a_jump_target: assert property (@(posedge clk) disable iff (reset)
		jump_target == exp_jump_target)
		else report_mismatch("jump_target", $sampled(jump_target), $sampled(exp_jump_target));
	a_jr_target: assert property (@(posedge clk) disable iff (reset)
		jump_reg_target == exp_jr_target)
		else report_mismatch("jump_reg_target", $sampled(jump_reg_target), $sampled(exp_jr_target));
	a_debug: assert property (@(posedge clk) disable iff (reset) debug_data == exp_debug)
		else report_mismatch("debug_data", $sampled(debug_data), $sampled(exp_debug));
	a_single_stall: assert property (@(posedge clk) disable iff (reset) stall |=> !stall)
		else begin
			other_errors++;
			$display("stall stayed high for more than one cycle at %0t", $time);
		end

	////////////////////////////////////////////////////////////
	// stimulus
	////////////////////////////////////////////////////////////
	task automatic drive_side(input bit flush_ok);
		logic [4:0] target;
		logic [4:0] dbg;
		target = 5'($urandom_range(0, 31));
		if ($urandom_range(0, 3) == 0)
			target = hazard ? m_if_id.instr[25:21] : fetch.instr[25:21]; // rs read in decode next
		dbg = ($urandom_range(0, 7) == 0) ? 5'd0 : 5'($urandom_range(0, 31));
		wb         <= '{reg_write: 1'($urandom_range(0, 1)), write_reg: target, write_data: $urandom};
		halt_in    <= 1'($urandom_range(0, 1));
		debug_addr <= dbg;
		flush      <= flush_ok && ($urandom_range(0, 15) == 0);
	endtask

	// present one instruction and hold it while decode stalls
	task automatic issue(input logic [31:0] instr, input bit flush_ok);
		@(posedge clk);
		while (stall)
		begin
			drive_side(flush_ok);
			@(posedge clk);
		end
		drive_side(flush_ok);
		fetch <= '{pc_plus4: pc + 32'd4, instr: instr};
		pc = pc + 32'd4;
	endtask

	initial
	begin
		logic [31:0] instr;
		logic [31:0] prev;
		void'($urandom(32'hfe60_d3b4));
		reset      = 1'b1;
		fetch      = '0;
		wb         = '0;
		flush      = 1'b0;
		halt_in    = 1'b0;
		debug_addr = '0;
		pc         = $urandom & 32'hffff_fffc;
		prev       = '0;
		repeat (16) @(posedge clk);
		reset <= 1'b0;
		repeat (4) @(posedge clk); // idle after reset
		repeat (20) issue('0, 1'b0); // nops while writebacks fill registers
		issue({mips_pkg::op_lw, 5'd1, 5'd5, 16'h0010}, 1'b0);
		issue({mips_pkg::op_rtype, 5'd5, 5'd7, 5'd6, 5'd0, mips_pkg::fn_add}, 1'b0);
		issue({mips_pkg::op_lw, 5'd2, 5'd9, 16'hfff0}, 1'b0);
		issue({mips_pkg::op_sw, 5'd3, 5'd9, 16'h0004}, 1'b0);
		issue({mips_pkg::op_lw, 5'd4, 5'd0, 16'h0008}, 1'b0); // load to r0
		issue({mips_pkg::op_rtype, 5'd0, 5'd0, 5'd10, 5'd0, mips_pkg::fn_add}, 1'b0);
		issue({mips_pkg::op_j, 26'h123_4567}, 1'b0);
		issue({mips_pkg::op_jal, 26'h3ff_fffc}, 1'b0);
		issue({mips_pkg::op_rtype, 5'd5, 15'd0, mips_pkg::fn_jr}, 1'b0);
		for (int i = 0; i < num_instr; i++)
		begin
			instr = random_instr(prev);
			issue(instr, 1'b1);
			prev = instr;
		end
		@(posedge clk);
		fetch <= '0;
		wb    <= '0;
		flush <= 1'b0;
		repeat (6) @(posedge clk);
		$display("errors: %0d wrong values, %0d other failures", value_errors, other_errors);
		if ((value_errors == 0) && (other_errors == 0))
			$display("PASS: all tests");
		else
			$display("FAIL: see errors above");
		$finish;
	end

	initial
	begin
		#((num_instr * 4 + 200) * clk_period);
		$display("timeout: the run did not finish in time");
		$display("FAIL: see errors above");
		$finish;
	end

endmodule

`default_nettype wire

/* vlog.f */
mips_pkg.sv
control_unit.sv
register_file.sv
hazard_unit.sv
if_id_register.sv
id_ex_stage.sv
decode_top.sv
tb_decode_top.sv
